// File: array_mul_defines.svh
`ifndef ARRAY_MUL_DEFINES_SVH
`define ARRAY_MUL_DEFINES_SVH

// Operand width of multiplier and multiplicand
`define MUL_WIDTH 16

// Full two's-complement product
`define MUL_RESULT_WIDTH 32

// Bit-index counter, one step per multiplier bit
`define MUL_COUNT_WIDTH 4

`endif

// File: array_mul_pkg.sv
`include "array_mul_defines.svh"

`default_nettype none

package array_mul_pkg;

    // Controller states
    typedef enum logic [1:0] {
        IDLE  = 2'd0,                           // Waiting for start
        SHIFT = 2'd1,                           // One multiplier bit per cycle
        DONE  = 2'd2                            // Product valid pulse
    } mul_state_t;

    // Operands sampled on the start strobe
    typedef struct packed {
        logic [`MUL_WIDTH-1:0] multiplier;      // Bits consumed LSB first
        logic [`MUL_WIDTH-1:0] multiplicand;    // Added per set bit
    } mul_operands_t;

    // Per-cycle control from controller to datapath
    typedef struct packed {
        logic                        active;    // Step in progress
        logic                        first;     // Index 0, clears the sum
        logic                        last_bit;  // Sign-bit step, index 15
        logic [`MUL_COUNT_WIDTH-1:0] bit_index; // Current multiplier bit
    } mul_step_t;

endpackage

`default_nettype wire

// File: mul_controller.sv
`include "array_mul_defines.svh"

`default_nettype none
`timescale 1ns/1ps

module mul_controller import array_mul_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      start,
    output mul_step_t step,
    output logic      load,
    output logic      busy,
    output logic      done
);

    mul_state_t                  state, next_state;
    logic [`MUL_COUNT_WIDTH-1:0] count;      // Bit index of the running step
    logic                        last_count; // Sign-bit index reached

    assign last_count = (count == {`MUL_COUNT_WIDTH{1'b1}});

    always_comb begin
        next_state = state;
        case (state)
            IDLE:    if (start) next_state = SHIFT;      // Accept only when idle
            SHIFT:   if (last_count) next_state = DONE;  // After bit 15
            DONE:    next_state = IDLE;                  // Single-cycle done
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= IDLE;
            count <= '0;
        end else begin
            state <= next_state;
            if (state == SHIFT) begin
                count <= count + 1'b1;               // Wraps to 0 after bit 15
            end else begin
                count <= '0;
            end
        end
    end

    assign load = start && (state == IDLE);         // Capture operands at E0
    assign busy = (state == SHIFT);
    assign done = (state == DONE);

    assign step.active    = busy;
    assign step.first     = busy && (count == '0);  // Sum starts from zero
    assign step.last_bit  = busy && last_count;     // Negated partial product
    assign step.bit_index = count;

    // Sign-bit step comes 15 steps after the first, then done
    assert property (@(posedge clk) disable iff (!reset)
        step.last_bit |-> $past(step.first, 15) ##1 done);

    // Done is a pulse, 17 cycles after the accepted start
    assert property (@(posedge clk) disable iff (!reset)
        done |-> $past(load, 17) ##1 !done);

endmodule

`default_nettype wire

// File: multiplier_shift_register.sv
`include "array_mul_defines.svh"

`default_nettype none
`timescale 1ns/1ps

module multiplier_shift_register import array_mul_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  load,
    input  logic [`MUL_WIDTH-1:0] multiplier,
    input  logic                  shift_en,
    output logic                  bit_out
);

    logic [`MUL_WIDTH-1:0] shift_q; // Remaining multiplier bits

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            shift_q <= '0;
        end else if (load) begin
            shift_q <= multiplier;                  // Bit 0 ready for index 0
        end else if (shift_en) begin
            shift_q <= {1'b0, shift_q[`MUL_WIDTH-1:1]}; // Next bit into LSB
        end
    end

    // LSB always matches the controller's bit index
    assign bit_out = shift_q[0];

endmodule

`default_nettype wire

// File: partial_product_gen.sv
`include "array_mul_defines.svh"

`default_nettype none
`timescale 1ns/1ps

module partial_product_gen import array_mul_pkg::*; (
    input  logic [`MUL_WIDTH-1:0]        multiplicand,
    input  logic                         mul_bit,
    input  mul_step_t                    step,
    output logic [`MUL_RESULT_WIDTH-1:0] partial
);

    logic [`MUL_WIDTH-1:0]        selected; // Multiplicand or zero
    logic [`MUL_RESULT_WIDTH-1:0] extended; // Sign-extended to product width
    logic [`MUL_RESULT_WIDTH-1:0] signed_pp; // After optional negation

    always_comb begin
        // Bit gates the multiplicand
        if (mul_bit) begin
            selected = multiplicand;
        end else begin
            selected = '0;
        end

        extended = {{(`MUL_RESULT_WIDTH-`MUL_WIDTH){selected[`MUL_WIDTH-1]}}, selected};

        // Multiplier MSB carries weight -2^15
        if (step.last_bit) begin
            signed_pp = ~extended + 1'b1;
        end else begin
            signed_pp = extended;
        end

        partial = signed_pp << step.bit_index; // Weight by bit position
    end

endmodule

`default_nettype wire

// File: ripple_carry_adder.sv
`include "array_mul_defines.svh"

`default_nettype none
`timescale 1ns/1ps

module ripple_carry_adder (
    input  logic [`MUL_RESULT_WIDTH-1:0] a,
    input  logic [`MUL_RESULT_WIDTH-1:0] b,
    output logic [`MUL_RESULT_WIDTH-1:0] sum
);

    logic [`MUL_RESULT_WIDTH-1:0] carry; // Carry into each bit

    assign carry[0] = 1'b0;              // No carry-in

    genvar i;
    generate
        for (i = 0; i < `MUL_RESULT_WIDTH; i++) begin : g_bit
            // Full-adder sum
            assign sum[i] = a[i] ^ b[i] ^ carry[i];

            // Carry out of the top bit is dropped, result wraps mod 2^32
            if (i < `MUL_RESULT_WIDTH - 1) begin : g_carry
                assign carry[i+1] = (a[i] & b[i]) | (a[i] & carry[i]) | (b[i] & carry[i]);
            end
        end
    endgenerate

endmodule

`default_nettype wire

// File: product_accumulator.sv
`include "array_mul_defines.svh"

`default_nettype none
`timescale 1ns/1ps

module product_accumulator import array_mul_pkg::*; (
    input  logic                         clk,
    input  logic                         reset,
    input  mul_step_t                    step,
    input  logic [`MUL_RESULT_WIDTH-1:0] partial,
    output logic [`MUL_RESULT_WIDTH-1:0] product
);

    logic [`MUL_RESULT_WIDTH-1:0] addend; // Held sum or zero
    logic [`MUL_RESULT_WIDTH-1:0] next_sum;

    // First step starts a fresh sum
    assign addend = step.first ? '0 : product;

    ripple_carry_adder u_adder (
        .a   (partial),
        .b   (addend),
        .sum (next_sum)
    );

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            product <= '0;
        end else if (step.active) begin
            product <= next_sum;                 // One partial per step
        end
    end

    // Ripple chain gives the plain modulo-2^32 sum on every step
    assert property (@(posedge clk) disable iff (!reset)
        step.active |=> (product == $past(partial + addend)));

endmodule

`default_nettype wire

// File: array_multiplier_datapath.sv
`include "array_mul_defines.svh"

`default_nettype none
`timescale 1ns/1ps

module array_multiplier_datapath import array_mul_pkg::*; (
    input  logic                         clk,
    input  logic                         reset,
    input  mul_operands_t                operands,
    input  logic                         load,
    input  mul_step_t                    step,
    output logic [`MUL_RESULT_WIDTH-1:0] product
);

    logic [`MUL_WIDTH-1:0]        multiplicand_q; // Held for all 16 steps
    logic                         mul_bit;        // Current multiplier bit
    logic [`MUL_RESULT_WIDTH-1:0] partial;        // Shifted partial product

    always_ff @(posedge clk) begin
        if (load) begin
            multiplicand_q <= operands.multiplicand;
        end
    end

    multiplier_shift_register u_shift_register (
        .clk        (clk),
        .reset      (reset),
        .load       (load),
        .multiplier (operands.multiplier),
        .shift_en   (step.active),       // Advance once per step
        .bit_out    (mul_bit)
    );

    partial_product_gen u_partial_product_gen (
        .multiplicand (multiplicand_q),
        .mul_bit      (mul_bit),
        .step         (step),
        .partial      (partial)
    );

    product_accumulator u_product_accumulator (
        .clk     (clk),
        .reset   (reset),
        .step    (step),
        .partial (partial),
        .product (product)
    );

endmodule

`default_nettype wire

// File: array_multiplier.sv
`include "array_mul_defines.svh"

`default_nettype none
`timescale 1ns/1ps

module array_multiplier import array_mul_pkg::*; (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         start,
    input  mul_operands_t                operands,
    output logic [`MUL_RESULT_WIDTH-1:0] product,
    output logic                         done,
    output logic                         busy
);

    mul_step_t step; // Per-cycle control to datapath
    logic      load; // Operand capture strobe

    mul_controller u_controller (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .step  (step),
        .load  (load),
        .busy  (busy),
        .done  (done)
    );

    array_multiplier_datapath u_datapath (
        .clk      (clk),
        .reset    (reset),
        .operands (operands),
        .load     (load),
        .step     (step),
        .product  (product)
    );

endmodule

`default_nettype wire

// File: tb_array_multiplier.sv
`include "array_mul_defines.svh"

`default_nettype none
`timescale 1ns/1ps

module tb_array_multiplier import array_mul_pkg::*; ();

    localparam int DONE_TIMEOUT = 40; // Cycles allowed per multiplication
    localparam int RANDOM_PAIRS = 40;

    logic                         clk;
    logic                         reset;
    logic                         start;
    mul_operands_t                operands;
    logic [`MUL_RESULT_WIDTH-1:0] product;
    logic                         done;
    logic                         busy;
    logic [31:0]                  rand_state; // Xorshift state

    array_multiplier u_array_multiplier (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .operands (operands),
        .product  (product),
        .done     (done),
        .busy     (busy)
    );

    always #50 clk = ~clk; // 100 ns period

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Reference product, signed and wrapped to 32 bits
    function automatic logic [31:0] signed_product(input logic [`MUL_WIDTH-1:0] a,
                                                   input logic [`MUL_WIDTH-1:0] b);
        logic signed [31:0] a_ext;
        logic signed [31:0] b_ext;
        a_ext = $signed(a); // Sign extension
        b_ext = $signed(b);
        return a_ext * b_ext;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            stop_on_error($sformatf("Mismatch %s: expected %h, actual %h",
                                    name, expected, actual));
        end
    endtask

    // One multiplication, optionally with a second start while busy
    task automatic run_mul(input string name, input logic [`MUL_WIDTH-1:0] mplr,
                           input logic [`MUL_WIDTH-1:0] mcnd, input logic [31:0] expected,
                           input bit interfere);
        int cycles;
        int busy_cycles;
        int idle_cycles;
        cycles      = 0;
        busy_cycles = 0;
        idle_cycles = interfere ? 20 : 3; // Longer watch for a stray second done
        @(posedge clk);
        start    <= 1'b1;
        operands <= '{multiplier: mplr, multiplicand: mcnd};
        @(posedge clk);                   // E0 samples the strobe
        start <= 1'b0;
        do begin
            @(negedge clk);
            cycles++;
            if (busy) busy_cycles++;
            if (!done) begin
                if (cycles >= DONE_TIMEOUT) begin
                    stop_on_error($sformatf("Timed out waiting for done in %s", name));
                end
                @(posedge clk);
                start <= interfere && (cycles == 4); // Strobe in the middle of SHIFT
                if (interfere && (cycles == 4)) begin
                    operands <= '{multiplier: ~mplr, multiplicand: ~mcnd};
                end
            end
        end while (!done);
        check_value({name, " cycles to done"}, 32'd17, cycles);
        check_value({name, " busy cycles"}, 32'd16, busy_cycles);
        check_value({name, " product"}, expected, product);
        repeat (idle_cycles) begin        // Held result, single done pulse
            @(negedge clk);
            check_value({name, " done after finish"}, 32'd0, done);
            check_value({name, " busy after finish"}, 32'd0, busy);
            check_value({name, " held product"}, expected, product);
        end
    endtask

    initial begin
        int                    fd;
        int                    vector_count;
        string                 line;
        logic [`MUL_WIDTH-1:0] mplr;
        logic [`MUL_WIDTH-1:0] mcnd;
        logic [31:0]           expected;
        clk          = 1'b0;
        reset        = 1'b0;
        start        = 1'b0;
        operands     = '0;
        rand_state   = 32'h8b6fb18e;
        vector_count = 0;
        line         = "";
        repeat (2) @(posedge clk);
        reset <= 1'b1;
        @(negedge clk);
        check_value("reset done", 32'd0, done);
        check_value("reset busy", 32'd0, busy);
        check_value("reset product", 32'd0, product);

        fd = $fopen("array_mul_input.txt", "r");
        if (fd == 0) begin
            stop_on_error("Could not open array_mul_input.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if ($sscanf(line, "%h %h %h", mplr, mcnd, expected) == 3) begin // Skips comments
                vector_count++;
                run_mul($sformatf("vector_%0d", vector_count), mplr, mcnd, expected, 1'b0);
            end
        end
        $fclose(fd);
        if (vector_count == 0) begin
            stop_on_error("No vectors found in array_mul_input.txt");
        end

        run_mul("busy_start", 16'h0003, 16'hfffb, signed_product(16'h0003, 16'hfffb), 1'b1);

        for (int i = 0; i < RANDOM_PAIRS; i++) begin
            rand_state = xorshift32(rand_state);
            mplr       = rand_state[`MUL_WIDTH-1:0];
            rand_state = xorshift32(rand_state);
            mcnd       = rand_state[`MUL_WIDTH-1:0];
            run_mul($sformatf("random_%0d", i), mplr, mcnd, signed_product(mplr, mcnd), 1'b0);
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+.
array_mul_pkg.sv
mul_controller.sv
multiplier_shift_register.sv
partial_product_gen.sv
ripple_carry_adder.sv
product_accumulator.sv
array_multiplier_datapath.sv
array_multiplier.sv
tb_array_multiplier.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_array_multiplier
FILELIST  = sim.f
BUILD_DIR = obj_dir
PASS_MSG  = *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

// File: array_mul_input.txt
// multiplier multiplicand expected_product (hex, signed 16 x 16 -> 32)
// one vector per line
0000 0000 00000000
0000 1234 00000000
0001 ffff ffffffff
ffff 0001 ffffffff
8000 8000 40000000
0003 fffb fffffff1
fffb 0003 fffffff1
7fff 7fff 3fff0001
7fff 8000 c0008000
8000 ffff 00008000
0064 ff9c ffffd8f0
1234 0010 00012340
ffff ffff 00000001
00ff 0100 0000ff00
